// ==== design/synth_config.svh ====
`ifndef SYNTH_CONFIG_SVH
`define SYNTH_CONFIG_SVH

// number of voice banks in the generate loop
`define SYNTH_VOICE_COUNT 4

// bank select field of the command word
`define SYNTH_BANK_LSB 23
`define SYNTH_BANK_MSB 27

// half period field, bits 22 to 0
`define SYNTH_PERIOD_BITS 23

// envelope targets
`define SYNTH_ENV_PEAK 16'h4000
`define SYNTH_ENV_SUSTAIN 16'h2000

// per-cycle envelope steps, each divides its span exactly
`define SYNTH_ATTACK_STEP 16'h0400
`define SYNTH_DECAY_STEP 16'h0200
`define SYNTH_RELEASE_STEP 16'h0100

`endif

// ==== design/synth_pkg.sv ====
`include "synth_config.svh"

package synth_pkg;

  // raw note command from the host
  typedef logic [31:0] cmd_word_t;

  // voice bank index, as wide as the bank field
  typedef logic [`SYNTH_BANK_MSB-`SYNTH_BANK_LSB:0] bank_t;

  // half period in clk_calc cycles
  typedef logic [`SYNTH_PERIOD_BITS-1:0] period_t;

  // unsigned envelope amplitude
  typedef logic [15:0] level_t;

  // signed sample, per bank and for the mixed audio
  typedef logic signed [23:0] sample_t;

  // envelope phases
  typedef enum logic [2:0] {
    env_idle,
    env_attack,
    env_decay,
    env_sustain,
    env_release
  } env_state_t;

endpackage

// ==== design/voice_if.sv ====
`timescale 1ns/1ps

// one voice bank's control and result signals
interface voice_if;

  // one-cycle strobes from the dispatcher, never both high
  logic note_on;
  logic note_off;
  // half period, valid from the note_on edge
  synth_pkg::period_t period;

  // signed bank output, combinational
  synth_pkg::sample_t sample;
  // end of release, one cycle
  logic done;

  // command side
  modport dispatch_mp (
    output note_on,
    output note_off,
    output period
  );

  // the bank itself
  modport voice_mp (
    input  note_on,
    input  note_off,
    input  period,
    output sample,
    output done
  );

  // summing side
  modport mix_mp (
    input sample,
    input done
  );

endinterface

// ==== design/tone_osc.sv ====
`timescale 1ns/1ps

module tone_osc (
  input  logic               clk_calc,
  input  logic               rst_n,
  input  logic               restart,
  input  synth_pkg::period_t period,
  output logic               tone
);

  // cycles spent in the current phase, 1 based
  synth_pkg::period_t cnt;

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      cnt  <= '0;
      tone <= 1'b0;
    end else if (restart) begin
      // note start, high phase from this edge
      cnt  <= synth_pkg::period_t'(1);
      tone <= 1'b1;
    end else if (period == '0) begin
      // no period, park high
      cnt  <= synth_pkg::period_t'(1);
      tone <= 1'b1;
    end else if (cnt >= period) begin
      // phase complete after period cycles
      cnt  <= synth_pkg::period_t'(1);
      tone <= ~tone;
    end else begin
      cnt  <= cnt + synth_pkg::period_t'(1);
    end
  end

endmodule

// ==== design/adsr_envelope.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module adsr_envelope (
  input  logic              clk_calc,
  input  logic              rst_n,
  input  logic              gate_on,
  input  logic              gate_off,
  output synth_pkg::level_t level,
  output logic              done
);

  synth_pkg::env_state_t state;
  // phase that applies this cycle, strobes included
  synth_pkg::env_state_t mode;

  // candidate levels, each saturating at its target
  synth_pkg::level_t level_up;
  synth_pkg::level_t level_dn;
  synth_pkg::level_t level_rel;
  logic              rel_end;

  assign level_up = (level >= synth_pkg::level_t'(`SYNTH_ENV_PEAK - `SYNTH_ATTACK_STEP)) ?
                    `SYNTH_ENV_PEAK : level + `SYNTH_ATTACK_STEP;

  assign level_dn = (level <= synth_pkg::level_t'(`SYNTH_ENV_SUSTAIN + `SYNTH_DECAY_STEP)) ?
                    `SYNTH_ENV_SUSTAIN : level - `SYNTH_DECAY_STEP;

  // release hits zero on this step
  assign rel_end   = (level <= `SYNTH_RELEASE_STEP);
  assign level_rel = rel_end ? '0 : level - `SYNTH_RELEASE_STEP;

  // note_on retriggers from any state, current level kept
  // note_off only acts on a sounding note
  always_comb begin
    mode = state;
    if (gate_on) begin
      mode = synth_pkg::env_attack;
    end else if (gate_off && (state != synth_pkg::env_idle) &&
                 (state != synth_pkg::env_release)) begin
      mode = synth_pkg::env_release;
    end
  end

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      state <= synth_pkg::env_idle;
      level <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (mode)
        synth_pkg::env_attack: begin
          level <= level_up;
          // go on to decay once peak is held
          state <= (level_up == `SYNTH_ENV_PEAK) ? synth_pkg::env_decay
                                                 : synth_pkg::env_attack;
        end
        synth_pkg::env_decay: begin
          level <= level_dn;
          state <= (level_dn == `SYNTH_ENV_SUSTAIN) ? synth_pkg::env_sustain
                                                    : synth_pkg::env_decay;
        end
        synth_pkg::env_sustain: begin
          // hold until gate_off
          state <= synth_pkg::env_sustain;
        end
        synth_pkg::env_release: begin
          level <= level_rel;
          if (rel_end) begin
            // note finished, report and rest
            done  <= 1'b1;
            state <= synth_pkg::env_idle;
          end else begin
            state <= synth_pkg::env_release;
          end
        end
        default: begin
          state <= synth_pkg::env_idle;
        end
      endcase
    end
  end

endmodule

// ==== design/synth_voice.sv ====
`timescale 1ns/1ps

module synth_voice (
  input logic      clk_calc,
  input logic      rst_n,
  voice_if.voice_mp bus
);

  logic              tone;
  synth_pkg::level_t level;
  // level widened to sample width, always positive
  synth_pkg::sample_t mag;

  // square wave restarts with each note
  tone_osc i_osc (
    .clk_calc (clk_calc),
    .rst_n    (rst_n),
    .restart  (bus.note_on),
    .period   (bus.period),
    .tone     (tone)
  );

  // amplitude shaping, done goes straight to the mixer
  adsr_envelope i_env (
    .clk_calc (clk_calc),
    .rst_n    (rst_n),
    .gate_on  (bus.note_on),
    .gate_off (bus.note_off),
    .level    (level),
    .done     (bus.done)
  );

  assign mag = {{($bits(synth_pkg::sample_t) - $bits(synth_pkg::level_t)){1'b0}}, level};

  // high phase gives +level, low phase -level
  assign bus.sample = tone ? mag : -mag;

endmodule

// ==== design/note_dispatcher.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module note_dispatcher (
  input  logic                clk_calc,
  input  logic                rst_n,
  input  logic                cmd_valid,
  input  synth_pkg::cmd_word_t cmd_data,
  voice_if.dispatch_mp        voices [`SYNTH_VOICE_COUNT]
);

  // first stage holds the captured command
  logic               cmd_valid_q;
  synth_pkg::bank_t   bank_q;
  synth_pkg::period_t period_q;

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      cmd_valid_q <= 1'b0;
    end else begin
      cmd_valid_q <= cmd_valid;
    end
  end

  // bank and period fields of the incoming word
  always_ff @(posedge clk_calc) begin
    bank_q   <= cmd_data[`SYNTH_BANK_MSB:`SYNTH_BANK_LSB];
    period_q <= cmd_data[`SYNTH_PERIOD_BITS-1:0];
  end

  // second stage has one strobe register set per bank
  // out of range banks match no index and drop out here
  for (genvar i = 0; i < `SYNTH_VOICE_COUNT; i++) begin : g_bank
    logic hit;

    assign hit = cmd_valid_q && (bank_q == synth_pkg::bank_t'(i));

    always_ff @(posedge clk_calc or negedge rst_n) begin
      if (!rst_n) begin
        voices[i].note_on  <= 1'b0;
        voices[i].note_off <= 1'b0;
        voices[i].period   <= '0;
      end else begin
        // strobes clear by themselves on the next cycle
        voices[i].note_on  <= hit && (period_q != '0);
        voices[i].note_off <= hit && (period_q == '0);
        // new period lands with note_on
        if (hit && (period_q != '0)) begin
          voices[i].period <= period_q;
        end
      end
    end
  end

endmodule

// ==== design/voice_mixer.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module voice_mixer (
  input  logic               clk_calc,
  input  logic               rst_n,
  voice_if.mix_mp            voices [`SYNTH_VOICE_COUNT],
  output synth_pkg::sample_t audio,
  output logic               done_valid,
  output synth_pkg::bank_t   done_bank
);

  // flat copies of the bank outputs
  synth_pkg::sample_t             bank_sample [`SYNTH_VOICE_COUNT];
  logic [`SYNTH_VOICE_COUNT-1:0] bank_done;

  synth_pkg::sample_t sum;
  synth_pkg::bank_t   last_done;

  for (genvar i = 0; i < `SYNTH_VOICE_COUNT; i++) begin : g_tap
    assign bank_sample[i] = voices[i].sample;
    assign bank_done[i]   = voices[i].done;
  end

  // signed sum with headroom for all banks at peak
  // later banks win the index
  always_comb begin
    sum       = '0;
    last_done = '0;
    for (int i = 0; i < `SYNTH_VOICE_COUNT; i++) begin
      sum = sum + bank_sample[i];
      if (bank_done[i]) begin
        last_done = synth_pkg::bank_t'(i);
      end
    end
  end

  always_ff @(posedge clk_calc or negedge rst_n) begin
    if (!rst_n) begin
      audio      <= '0;
      done_valid <= 1'b0;
      done_bank  <= '0;
    end else begin
      audio      <= sum;
      done_valid <= |bank_done;
      // index holds between reports
      if (|bank_done) begin
        done_bank <= last_done;
      end
    end
  end

endmodule

// ==== design/synth_top.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module synth_top (
  input  logic                 clk_calc,
  input  logic                 rst_n,
  input  logic                 cmd_valid,
  input  synth_pkg::cmd_word_t cmd_data,
  output synth_pkg::sample_t   audio,
  output logic                 done_valid,
  output synth_pkg::bank_t     done_bank
);

  // one bundle per bank
  voice_if voices [`SYNTH_VOICE_COUNT] ();

  // command word to per-bank strobes and periods
  note_dispatcher i_dispatcher (
    .clk_calc  (clk_calc),
    .rst_n     (rst_n),
    .cmd_valid (cmd_valid),
    .cmd_data  (cmd_data),
    .voices    (voices)
  );

  // identical banks
  for (genvar i = 0; i < `SYNTH_VOICE_COUNT; i++) begin : g_voice
    synth_voice i_voice (
      .clk_calc (clk_calc),
      .rst_n    (rst_n),
      .bus      (voices[i])
    );
  end

  // sum to audio, report finished notes
  voice_mixer i_mixer (
    .clk_calc   (clk_calc),
    .rst_n      (rst_n),
    .voices     (voices),
    .audio      (audio),
    .done_valid (done_valid),
    .done_bank  (done_bank)
  );

endmodule

// ==== test/synth_tb_tasks.svh ====
// command word from a bank field and a half period
function automatic synth_pkg::cmd_word_t make_cmd(int bank, int period);
  synth_pkg::cmd_word_t w;
  w = '0;
  w[`SYNTH_BANK_MSB:`SYNTH_BANK_LSB] = synth_pkg::bank_t'(bank);
  w[`SYNTH_PERIOD_BITS-1:0]          = synth_pkg::period_t'(period);
  return w;
endfunction

// strobe stays up, so calls can run back to back
task automatic send_cmd(int bank, int period);
  @(posedge clk_calc);
  cmd_valid <= 1'b1;
  cmd_data  <= make_cmd(bank, period);
endtask

task automatic end_cmds();
  @(posedge clk_calc);
  cmd_valid <= 1'b0;
  cmd_data  <= '0;
endtask

function automatic int magnitude(synth_pkg::sample_t s);
  int v;
  v = int'(s);
  return (v < 0) ? -v : v;
endfunction

task automatic begin_test(string name);
  test_name   = name;
  test_errors = 0;
endtask

task automatic end_test();
  tests_run++;
  if (test_errors == 0) begin
    $display("test %s ok", test_name);
  end else begin
    tests_failed++;
    $display("test %s had %0d errors", test_name, test_errors);
  end
endtask

task automatic check_value(string what, int expected, int actual);
  checks++;
  assert (actual == expected) else begin
    $display("FAIL %s: %s expected %0d actual %0d", test_name, what, expected, actual);
    errors++;
    test_errors++;
  end
endtask

task automatic check_true(bit cond, string msg);
  checks++;
  assert (cond) else begin
    $display("error in %s: %s", test_name, msg);
    errors++;
    test_errors++;
  end
endtask

// silent outputs for a number of cycles
task automatic quiet_check(int cycles);
  int n;
  for (n = 0; n < cycles; n++) begin
    @(negedge clk_calc);
    check_value("idle audio", 0, int'(audio));
    check_true(!done_valid, "done_valid pulsed with no note finishing");
  end
endtask

// |audio| lands on target, no done while a note sounds
task automatic wait_mag(int target, int limit, string what, output int peak);
  int n;
  int m;
  peak = 0;
  for (n = 0; n < limit; n++) begin
    @(negedge clk_calc);
    m = magnitude(audio);
    if (m > peak) begin
      peak = m;
    end
    check_true(!done_valid, "done_valid pulsed while the note was sounding");
    if (m == target) begin
      return;
    end
  end
  abort_run(what);
endtask

task automatic wait_done(int limit, string what);
  int n;
  for (n = 0; n < limit; n++) begin
    @(negedge clk_calc);
    if (done_valid) begin
      return;
    end
  end
  abort_run(what);
endtask

// cycles to the next sign change, magnitude held meanwhile
task automatic sign_interval(int expect_mag, int limit, output int cycles);
  bit neg_prev;
  int n;
  neg_prev = (int'(audio) < 0);
  cycles   = 0;
  for (n = 1; n <= limit; n++) begin
    @(negedge clk_calc);
    check_value("sustain magnitude", expect_mag, magnitude(audio));
    if ((int'(audio) < 0) != neg_prev) begin
      cycles = n;
      return;
    end
  end
  abort_run("audio never changed sign");
endtask

// largest |audio| over a fixed window
task automatic observe_peak(int cycles, output int peak);
  int n;
  int m;
  peak = 0;
  for (n = 0; n < cycles; n++) begin
    @(negedge clk_calc);
    m = magnitude(audio);
    if (m > peak) begin
      peak = m;
    end
    check_true(!done_valid, "done_valid pulsed while all banks were held");
  end
endtask

// ==== test/synth_tb.sv ====
`timescale 1ns/1ps
`include "synth_config.svh"

module synth_tb;

  localparam int voice_count = `SYNTH_VOICE_COUNT;
  localparam int peak_mag    = int'(`SYNTH_ENV_PEAK);
  localparam int sustain_mag = int'(`SYNTH_ENV_SUSTAIN);
  // first decay step below the peak
  localparam int decay_start = peak_mag - int'(`SYNTH_DECAY_STEP);
  // bank field can address more banks than exist
  localparam int bank_span   = 2 ** $bits(synth_pkg::bank_t);
  // steps from note_on to sustain through attack and decay
  localparam int settle_cycles = peak_mag / int'(`SYNTH_ATTACK_STEP) +
                                 (peak_mag - sustain_mag) / int'(`SYNTH_DECAY_STEP);
  localparam int wait_limit      = 400;
  localparam int watchdog_cycles = 20000;

  logic                 clk_calc;
  logic                 rst_n;
  logic                 cmd_valid;
  synth_pkg::cmd_word_t cmd_data;
  synth_pkg::sample_t   audio;
  logic                 done_valid;
  synth_pkg::bank_t     done_bank;

  // run bookkeeping
  int    errors;
  int    checks;
  int    tests_run;
  int    tests_failed;
  int    test_errors;
  string test_name;
  bit    aborted;
  event  abort_ev;

  synth_top i_dut (
    .clk_calc   (clk_calc),
    .rst_n      (rst_n),
    .cmd_valid  (cmd_valid),
    .cmd_data   (cmd_data),
    .audio      (audio),
    .done_valid (done_valid),
    .done_bank  (done_bank)
  );

  `include "synth_tb_tasks.svh"

  // stop the sequence when a wait runs out
  task automatic abort_run(string reason);
    $display("timeout in %s: %s", test_name, reason);
    aborted = 1'b1;
    -> abort_ev;
  endtask

  task automatic run_tests();
    int bank;
    int period;
    int peak;
    int gap;
    int order [voice_count];
    int reports [voice_count];
    int j;
    int tmp;

    begin_test("reset_idle");
    quiet_check(20);
    end_test();

    // envelope shape and sustain half period of one note
    begin_test("single_note");
    bank   = int'($urandom % voice_count);
    period = 4 + int'($urandom % 37);
    send_cmd(bank, period);
    end_cmds();
    wait_mag(peak_mag, wait_limit, "attack never reached the peak level", peak);
    check_value("attack peak", peak_mag, peak);
    wait_mag(sustain_mag, wait_limit, "decay never reached the sustain level", peak);
    // peak lasts one cycle before decay steps down
    check_value("decay start", decay_start, peak);
    // first sign change only lines up the count
    sign_interval(sustain_mag, wait_limit, gap);
    repeat (2) begin
      sign_interval(sustain_mag, wait_limit, gap);
      check_value("half period", period, gap);
    end
    end_test();

    // zero period releases the same bank
    begin_test("release_done");
    send_cmd(bank, 0);
    end_cmds();
    wait_done(wait_limit, "no done pulse after the release");
    check_value("done_bank", bank, int'(done_bank));
    check_value("audio at done", 0, int'(audio));
    quiet_check(30);
    end_test();

    begin_test("all_banks");
    period = 4 + int'($urandom % 37);
    for (j = 0; j < voice_count; j++) begin
      send_cmd(j, period);
    end
    end_cmds();
    // fixed envelope time plus dispatch and bank offsets
    repeat (settle_cycles + voice_count + 4) @(negedge clk_calc);
    observe_peak(2 * period + voice_count, peak);
    check_value("summed sustain", voice_count * sustain_mag, peak);
    for (j = 0; j < voice_count; j++) begin
      order[j]   = j;
      reports[j] = 0;
    end
    // shuffle release order
    for (j = voice_count - 1; j > 0; j--) begin
      tmp        = int'($urandom % (j + 1));
      gap        = order[j];
      order[j]   = order[tmp];
      order[tmp] = gap;
    end
    for (j = 0; j < voice_count; j++) begin
      send_cmd(order[j], 0);
      end_cmds();
      wait_done(wait_limit, "a released bank never reported done");
      check_value("released bank", order[j], int'(done_bank));
      if (int'(done_bank) < voice_count) begin
        reports[int'(done_bank)]++;
      end
    end
    for (j = 0; j < voice_count; j++) begin
      check_value("reports per bank", 1, reports[j]);
    end
    check_value("audio after releases", 0, int'(audio));
    end_test();

    // bank field past the last bank
    begin_test("bad_bank");
    send_cmd(voice_count + int'($urandom % (bank_span - voice_count)),
             4 + int'($urandom % 37));
    end_cmds();
    quiet_check(40);
    end_test();

    // note_on in mid release goes back through attack
    begin_test("retrigger");
    bank   = int'($urandom % voice_count);
    period = 4 + int'($urandom % 37);
    send_cmd(bank, period);
    end_cmds();
    wait_mag(peak_mag, wait_limit, "attack never reached the peak level", peak);
    wait_mag(sustain_mag, wait_limit, "decay never reached the sustain level", peak);
    send_cmd(bank, 0);
    end_cmds();
    wait_mag(sustain_mag / 2, wait_limit, "release never reached half level", peak);
    send_cmd(bank, period);
    end_cmds();
    wait_mag(peak_mag, wait_limit, "retrigger never reached the peak level", peak);
    wait_mag(sustain_mag, wait_limit, "retrigger never returned to sustain", peak);
    sign_interval(sustain_mag, wait_limit, gap);
    sign_interval(sustain_mag, wait_limit, gap);
    check_value("half period after retrigger", period, gap);
    // leave the bank idle
    send_cmd(bank, 0);
    end_cmds();
    wait_done(wait_limit, "no done pulse after the final release");
    check_value("done_bank", bank, int'(done_bank));
    end_test();
  endtask

  initial begin
    clk_calc = 1'b0;
    forever begin
      #10;
      clk_calc = ~clk_calc;
    end
  end

  // overall limit on top of the per-wait limits
  initial begin
    repeat (watchdog_cycles) @(posedge clk_calc);
    abort_run("the run took longer than the overall cycle limit");
  end

  initial begin
    void'($urandom(32'h77e8_d6d3));
    rst_n     = 1'b0;
    cmd_valid = 1'b0;
    cmd_data  = '0;
    repeat (10) @(posedge clk_calc);
    rst_n <= 1'b1;
    fork
      run_tests();
      begin
        @(abort_ev);
      end
    join_any
    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && !aborted) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+design
+incdir+test
design/synth_pkg.sv
design/voice_if.sv
design/tone_osc.sv
design/adsr_envelope.sv
design/synth_voice.sv
design/note_dispatcher.sv
design/voice_mixer.sv
design/synth_top.sv
test/synth_tb.sv

// ==== Makefile ====
# Verilator build and run of the synthesizer testbench

VERILATOR ?= verilator
TOP       ?= synth_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
PASS_MSG  ?= PASS: all tests

.PHONY: sim clean

# build, run, then look for the pass line in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
